/* source/mips_pkg.sv */
package mips_pkg;

    localparam int word_w = 32;

    typedef logic [word_w-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    localparam word_t reset_vector = 32'hbfc00000;
    localparam reg_idx_t link_reg = 5'd31;
    localparam reg_idx_t v0_reg = 5'd2;

    // primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_blez    = 6'b000110,
        op_bgtz    = 6'b000111,
        op_addiu   = 6'b001001,
        op_slti    = 6'b001010,
        op_sltiu   = 6'b001011,
        op_andi    = 6'b001100,
        op_ori     = 6'b001101,
        op_xori    = 6'b001110,
        op_lui     = 6'b001111,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_t;

    // SPECIAL function field in bits 5:0
    typedef enum logic [5:0] {
        fn_sll  = 6'b000000,
        fn_srl  = 6'b000010,
        fn_sra  = 6'b000011,
        fn_sllv = 6'b000100,
        fn_srlv = 6'b000110,
        fn_srav = 6'b000111,
        fn_jr   = 6'b001000,
        fn_jalr = 6'b001001,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_xor  = 6'b100110,
        fn_slt  = 6'b101010,
        fn_sltu = 6'b101011
    } funct_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_link
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_gtz,
        br_lez,
        br_jimm,
        br_jreg
    } branch_t;

    typedef struct packed {
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    dest;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic [25:0] jidx;
        alu_op_t     alu_op;
        branch_t     branch;
        logic        use_imm;
        logic        sign_ext;
        logic        var_shift;
        logic        reg_write;
        logic        link;
        logic        load;
        logic        store;
    } decoded_t;

    typedef struct packed {
        word_t    result;
        word_t    mem_addr;
        word_t    store_data;
        logic     branch_taken;
        word_t    branch_target;
        reg_idx_t dest;
        logic     reg_write;
        logic     load;
        logic     store;
    } exec_t;

endpackage

/* source/mips_fetch.sv */
module mips_fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t pc,
    output logic            run,
    output logic            active,
    output logic            retire
);
    import mips_pkg::*;

    logic  redirect_pending;
    word_t pending_target;
    logic  pc_zero;

    assign pc_zero = (pc == '0);
    assign retire = run & clk_enable & ~pc_zero;
    assign active = run;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
            run <= 1'b1;
            redirect_pending <= 1'b0;
        end else if (run && clk_enable) begin
            if (pc_zero) begin
                // the word at address zero never runs
                run <= 1'b0;
            end else begin
                // redirect from the branch before the delay slot lands now
                if (redirect_pending) begin
                    pc <= pending_target;
                end else begin
                    pc <= pc + 32'd4;
                end
                redirect_pending <= branch_taken;
            end
        end
    end

    // target is held for one retired instruction
    always_ff @(posedge clk) begin
        if (retire && branch_taken) begin
            pending_target <= branch_target;
        end
    end

endmodule

/* source/mips_decode.sv */
module mips_decode (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct = funct_t'(instr[5:0]);
    assign rd = instr[15:11];

    always_comb begin
        // unlisted codes fall through as a no-op
        dec = '0;
        dec.rs = instr[25:21];
        dec.rt = instr[20:16];
        dec.dest = instr[20:16];
        dec.shamt = instr[10:6];
        dec.imm = instr[15:0];
        dec.jidx = instr[25:0];
        dec.alu_op = alu_add;
        dec.branch = br_none;

        case (opcode)
            op_special: begin
                dec.dest = rd;
                dec.reg_write = 1'b1;
                case (funct)
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_slt:  dec.alu_op = alu_slt;
                    fn_sltu: dec.alu_op = alu_sltu;
                    fn_sll:  dec.alu_op = alu_sll;
                    fn_srl:  dec.alu_op = alu_srl;
                    fn_sra:  dec.alu_op = alu_sra;
                    fn_sllv: begin
                        dec.alu_op = alu_sll;
                        dec.var_shift = 1'b1;
                    end
                    fn_srlv: begin
                        dec.alu_op = alu_srl;
                        dec.var_shift = 1'b1;
                    end
                    fn_srav: begin
                        dec.alu_op = alu_sra;
                        dec.var_shift = 1'b1;
                    end
                    fn_jr: begin
                        dec.branch = br_jreg;
                        dec.reg_write = 1'b0;
                    end
                    fn_jalr: begin
                        dec.branch = br_jreg;
                        dec.alu_op = alu_link;
                        dec.link = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            op_j: dec.branch = br_jimm;
            op_jal: begin
                dec.branch = br_jimm;
                dec.alu_op = alu_link;
                dec.link = 1'b1;
                dec.dest = link_reg;
                dec.reg_write = 1'b1;
            end
            op_beq:  dec.branch = br_eq;
            op_bne:  dec.branch = br_ne;
            op_bgtz: dec.branch = br_gtz;
            op_blez: dec.branch = br_lez;
            op_addiu, op_slti, op_sltiu: begin
                dec.use_imm = 1'b1;
                dec.sign_ext = 1'b1;
                dec.reg_write = 1'b1;
                if (opcode == op_slti) begin
                    dec.alu_op = alu_slt;
                end else if (opcode == op_sltiu) begin
                    dec.alu_op = alu_sltu;
                end
            end
            op_andi, op_ori, op_xori: begin
                // logical immediates stay zero-extended
                dec.use_imm = 1'b1;
                dec.reg_write = 1'b1;
                if (opcode == op_andi) begin
                    dec.alu_op = alu_and;
                end else if (opcode == op_ori) begin
                    dec.alu_op = alu_or;
                end else begin
                    dec.alu_op = alu_xor;
                end
            end
            op_lui: begin
                dec.alu_op = alu_lui;
                dec.use_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            op_lw: begin
                dec.load = 1'b1;
                dec.reg_write = 1'b1;
            end
            op_sw: dec.store = 1'b1;
            default: ;
        endcase
    end

endmodule

/* source/mips_regfile.sv */
module mips_regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               write_en,
    input  mips_pkg::reg_idx_t write_idx,
    input  mips_pkg::word_t    write_data,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != '0) begin
            // r0 is hardwired
            regs[write_idx] <= write_data;
        end
    end

    always_comb begin
        if (rs_idx == '0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_idx];
        end
    end

    always_comb begin
        if (rt_idx == '0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_idx];
        end
    end

    assign v0 = regs[v0_reg];

endmodule

/* source/mips_execute.sv */
module mips_execute (
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::word_t    pc,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output mips_pkg::exec_t    ex,
    output logic               branch_taken,
    output mips_pkg::word_t    branch_target
);
    import mips_pkg::*;

    word_t      imm_sext;
    word_t      imm_ext;
    word_t      link_addr;
    word_t      op_b;
    logic [4:0] shift_amt;
    word_t      alu_out;
    logic       taken;
    word_t      target;

    assign imm_sext = {{16{dec.imm[15]}}, dec.imm};
    assign imm_ext = dec.sign_ext ? imm_sext : {16'b0, dec.imm};

    // return address skips the delay slot
    assign link_addr = pc + 32'd8;

    always_comb begin
        if (dec.link) begin
            op_b = link_addr;
        end else if (dec.use_imm) begin
            op_b = imm_ext;
        end else begin
            op_b = rt_data;
        end
    end

    assign shift_amt = dec.var_shift ? rs_data[4:0] : dec.shamt;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_out = rs_data + op_b;
            alu_sub:  alu_out = rs_data - op_b;
            alu_and:  alu_out = rs_data & op_b;
            alu_or:   alu_out = rs_data | op_b;
            alu_xor:  alu_out = rs_data ^ op_b;
            alu_slt:  alu_out = {31'b0, $signed(rs_data) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, rs_data < op_b};
            alu_sll:  alu_out = op_b << shift_amt;
            alu_srl:  alu_out = op_b >> shift_amt;
            alu_sra:  alu_out = $signed(op_b) >>> shift_amt;
            alu_lui:  alu_out = {op_b[15:0], 16'b0};
            alu_link: alu_out = op_b;
            default:  alu_out = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (dec.branch)
            br_eq:   taken = (rs_data == rt_data);
            br_ne:   taken = (rs_data != rt_data);
            br_gtz:  taken = ($signed(rs_data) > 0);
            br_lez:  taken = ($signed(rs_data) <= 0);
            br_jimm: taken = 1'b1;
            br_jreg: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.branch)
            br_jimm: target = {pc[31:28], dec.jidx, 2'b00};
            br_jreg: target = rs_data;
            default: target = pc + 32'd4 + {imm_sext[29:0], 2'b00};
        endcase
    end

    assign branch_taken = taken;
    assign branch_target = target;

    always_comb begin
        ex.result = alu_out;
        // loads and stores always sign-extend the offset
        ex.mem_addr = rs_data + imm_sext;
        ex.store_data = rt_data;
        ex.branch_taken = taken;
        ex.branch_target = target;
        ex.dest = dec.dest;
        ex.reg_write = dec.reg_write;
        ex.load = dec.load;
        ex.store = dec.store;
    end

endmodule

/* source/mips_memwb.sv */
module mips_memwb (
    input  mips_pkg::exec_t    ex,
    input  logic               retire,
    input  mips_pkg::word_t    data_readdata,
    output mips_pkg::word_t    data_address,
    output mips_pkg::word_t    data_writedata,
    output logic               data_write,
    output logic               data_read,
    output logic               write_en,
    output mips_pkg::reg_idx_t write_idx,
    output mips_pkg::word_t    write_data
);

    assign data_address = ex.mem_addr;
    assign data_writedata = ex.store_data;

    // strobes only on a retiring cycle
    assign data_write = retire & ex.store;
    assign data_read = retire & ex.load;

    assign write_en = retire & ex.reg_write;
    assign write_idx = ex.dest;

    always_comb begin
        if (ex.load) begin
            write_data = data_readdata;
        end else begin
            write_data = ex.result;
        end
    end

endmodule

/* source/mips_cpu_harvard.sv */
module mips_cpu_harvard (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,

    input  logic        clk_enable,

    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    import mips_pkg::*;

    word_t    pc;
    logic     retire;
    logic     branch_taken;
    word_t    branch_target;
    decoded_t dec;
    word_t    rs_data;
    word_t    rt_data;
    exec_t    ex;
    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;

    assign instr_address = pc;

    mips_fetch i_mips_fetch (
        .clk           (clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .run           (),
        .active        (active),
        .retire        (retire)
    );

    mips_decode i_mips_decode (
        .instr (instr_readdata),
        .dec   (dec)
    );

    mips_regfile i_mips_regfile (
        .clk        (clk),
        .reset      (reset),
        .write_en   (wb_en),
        .write_idx  (wb_idx),
        .write_data (wb_data),
        .rs_idx     (dec.rs),
        .rt_idx     (dec.rt),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .v0         (register_v0)
    );

    mips_execute i_mips_execute (
        .dec           (dec),
        .pc            (pc),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .ex            (ex),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mips_memwb i_mips_memwb (
        .ex             (ex),
        .retire         (retire),
        .data_readdata  (data_readdata),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_write     (data_write),
        .data_read      (data_read),
        .write_en       (wb_en),
        .write_idx      (wb_idx),
        .write_data     (wb_data)
    );

endmodule

/* dv/mips_tb_programs.svh */
int prog_len;

function automatic word_t enc_r(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                logic [4:0] sa);
    return {6'b000000, rs, rt, rd, sa, fn};
endfunction

function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// index field is the word address inside the current 256 MB region
function automatic word_t enc_j(opcode_t op, word_t target);
    return {op, target[27:2]};
endfunction

task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
        imem[8'(i)] = 32'h0;
    end
    prog_len = 0;
endtask

task automatic emit(word_t instr);
    imem[8'(prog_len)] = instr;
    prog_len++;
endtask

task automatic emit_const(reg_idx_t rt, word_t value);
    emit(enc_i(op_lui, 5'd0, rt, value[31:16]));
    emit(enc_i(op_ori, rt, rt, value[15:0]));
endtask

// jr $31 plus delay slot; with r31 still zero this halts the core
task automatic emit_return();
    emit(enc_r(fn_jr, link_reg, 5'd0, 5'd0, 5'd0));
    emit(32'h0);
endtask

task automatic load_r_program(funct_t fn, word_t a, word_t b, logic [4:0] sa);
    clear_program();
    emit_const(5'd8, a);
    emit_const(5'd9, b);
    emit(enc_r(fn, 5'd8, 5'd9, v0_reg, sa));
    emit_return();
endtask

task automatic load_imm_program(opcode_t op, word_t a, logic [15:0] imm);
    clear_program();
    emit_const(5'd8, a);
    emit(enc_i(op, 5'd8, v0_reg, imm));
    emit_return();
endtask

// branch at word 5, delay slot at 6, skipped word 7, target word 8
task automatic load_branch_program(opcode_t op, word_t a, word_t b);
    reg_idx_t rt;
    rt = (op == op_bgtz || op == op_blez) ? 5'd0 : 5'd9;
    clear_program();
    emit_const(5'd8, a);
    emit_const(5'd9, b);
    emit(enc_i(op_addiu, 5'd0, v0_reg, 16'h0001));
    emit(enc_i(op, 5'd8, rt, 16'd2));
    emit(enc_i(op_addiu, v0_reg, v0_reg, 16'h0010));
    emit(enc_i(op_addiu, v0_reg, v0_reg, 16'h0100));
    emit(enc_i(op_addiu, v0_reg, v0_reg, 16'h1000));
    emit_return();
endtask

// call from word 2 into a subroutine at word 7 that copies r31 to v0
task automatic load_call_program(bit use_jalr);
    word_t sub_addr;
    sub_addr = reset_vector + 32'd28;
    clear_program();
    emit_const(5'd4, sub_addr);
    if (use_jalr) begin
        emit(enc_r(fn_jalr, 5'd4, 5'd0, link_reg, 5'd0));
    end else begin
        emit(enc_j(op_jal, sub_addr));
    end
    emit(32'h0);
    emit(enc_r(fn_or, 5'd0, 5'd0, link_reg, 5'd0));
    emit_return();
    emit(enc_r(fn_or, link_reg, 5'd0, v0_reg, 5'd0));
    emit_return();
endtask

task automatic load_jump_program();
    clear_program();
    emit(enc_i(op_addiu, 5'd0, v0_reg, 16'h0007));
    emit(enc_j(op_j, reset_vector + 32'd16));
    emit(enc_i(op_addiu, v0_reg, v0_reg, 16'h0001));
    emit(enc_i(op_addiu, v0_reg, v0_reg, 16'h0100));
    emit(enc_i(op_addiu, v0_reg, v0_reg, 16'h0020));
    emit_return();
endtask

task automatic load_mem_program(word_t value, word_t base, logic [15:0] offset);
    clear_program();
    emit_const(5'd8, value);
    emit_const(5'd9, base);
    emit(enc_i(op_sw, 5'd9, 5'd8, offset));
    emit(enc_i(op_lw, 5'd9, v0_reg, offset));
    emit_return();
endtask

/* dv/mips_tb.sv */
module mips_tb;
    import mips_pkg::*;

    logic  clk;
    logic  reset;
    logic  clk_enable;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic  data_write;
    logic  data_read;
    word_t data_writedata;
    word_t data_readdata;

    word_t imem [256];
    word_t dmem [256];

    // data bus activity seen by the memory model
    int    bus_reads;
    int    bus_writes;
    word_t read_addr;
    word_t write_addr;

    // operands of the last R-type run replayed under stalls
    funct_t     saved_fn;
    word_t      saved_a;
    word_t      saved_b;
    logic [4:0] saved_sa;
    word_t      saved_want;

    mips_cpu_harvard i_mips_cpu_harvard (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 1 KB program window at the reset vector
    // outside it an addiu that would clobber v0
    assign instr_readdata = (instr_address[31:10] == reset_vector[31:10]) ?
                            imem[instr_address[9:2]] : 32'h2402dead;
    assign data_readdata = dmem[data_address[9:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[8'(i)] <= 32'h5a5a0000 ^ (word_t'(i) << 2);
            end
            bus_reads <= 0;
            bus_writes <= 0;
        end else begin
            if (data_write) begin
                dmem[data_address[9:2]] <= data_writedata;
                bus_writes <= bus_writes + 1;
                write_addr <= data_address;
            end
            if (data_read) begin
                bus_reads <= bus_reads + 1;
                read_addr <= data_address;
            end
        end
    end

    `include "mips_tb_programs.svh"

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(string name, word_t got, word_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, want));
        end
    endtask

    function automatic word_t r_expected(funct_t fn, word_t a, word_t b, logic [4:0] sa);
        case (fn)
            fn_addu: return a + b;
            fn_subu: return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fn_sltu: return (a < b) ? 32'd1 : 32'd0;
            fn_sll:  return b << sa;
            fn_srl:  return b >> sa;
            fn_sra:  return $signed(b) >>> sa;
            fn_sllv: return b << a[4:0];
            fn_srlv: return b >> a[4:0];
            fn_srav: return $signed(b) >>> a[4:0];
            default: return 32'h0;
        endcase
    endfunction

    task automatic run_program(bit stall, int limit);
        int    cycles;
        int    hold;
        bit    stalled;
        word_t held_pc;
        @(negedge clk);
        reset = 1'b1;
        clk_enable = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        check_value("active", {31'b0, active}, 32'd1);
        check_value("instr_address", instr_address, reset_vector);
        cycles = 0;
        hold = 0;
        while (active) begin
            if (cycles == limit) begin
                abort_run("timeout: core did not halt within the cycle limit");
            end
            if (stall && hold == 0 && $urandom_range(3, 0) == 0) begin
                hold = $urandom_range(6, 1);
            end
            stalled = (hold > 0);
            if (stalled) begin
                hold--;
            end
            clk_enable = !stalled;
            held_pc = instr_address;
            @(negedge clk);
            if (stalled) begin
                check_value("instr_address", instr_address, held_pc);
            end
            cycles++;
        end
        // halted core must ignore a running clock
        clk_enable = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("active", {31'b0, active}, 32'd0);
            check_value("instr_address", instr_address, 32'h0);
            check_value("data_write", {31'b0, data_write}, 32'd0);
        end
    endtask

    task automatic test_r_type();
        funct_t     ops [13] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sltu,
                                 fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
        word_t      a;
        word_t      b;
        logic [4:0] sa;
        for (int k = 0; k < 13; k++) begin
            a = $urandom;
            b = $urandom;
            sa = 5'($urandom_range(31, 0));
            saved_fn = ops[k];
            saved_a = a;
            saved_b = b;
            saved_sa = sa;
            saved_want = r_expected(ops[k], a, b, sa);
            load_r_program(ops[k], a, b, sa);
            run_program(1'b0, 200);
            check_value("register_v0", register_v0, saved_want);
        end
    endtask

    task automatic imm_case(opcode_t op, word_t a, logic [15:0] imm, word_t want);
        load_imm_program(op, a, imm);
        run_program(1'b0, 200);
        check_value("register_v0", register_v0, want);
    endtask

    task automatic test_immediates();
        word_t a;
        a = $urandom;
        imm_case(op_addiu, a, 16'hfff3, a + 32'hfffffff3);
        imm_case(op_andi, a, 16'h8f0f, a & 32'h00008f0f);
        imm_case(op_ori, a, 16'h8f0f, a | 32'h00008f0f);
        imm_case(op_xori, a, 16'h8f0f, a ^ 32'h00008f0f);
        // 16'h8000 sign-extends to -32768 for both compares
        imm_case(op_slti, 32'hffff0000, 16'h8000, 32'd1);
        imm_case(op_slti, 32'h00001000, 16'h8000, 32'd0);
        imm_case(op_sltiu, 32'h00001000, 16'h8000, 32'd1);
        imm_case(op_sltiu, 32'hffffffff, 16'h8000, 32'd0);
        imm_case(op_lui, a, 16'hc3a5, 32'hc3a50000);
    endtask

    task automatic branch_case(opcode_t op, word_t a, word_t b);
        bit    taken;
        word_t want;
        case (op)
            op_beq:  taken = (a == b);
            op_bne:  taken = (a != b);
            op_bgtz: taken = ($signed(a) > 0);
            op_blez: taken = ($signed(a) <= 0);
            default: taken = 1'b0;
        endcase
        // delay slot always adds 0x10 and the skipped word would add 0x100
        want = taken ? 32'h00001011 : 32'h00001111;
        load_branch_program(op, a, b);
        run_program(1'b0, 200);
        check_value("register_v0", register_v0, want);
    endtask

    task automatic test_branches();
        word_t a;
        a = $urandom;
        branch_case(op_beq, a, a);
        branch_case(op_beq, a, ~a);
        branch_case(op_bne, a, a);
        branch_case(op_bne, a, ~a);
        branch_case(op_bgtz, 32'h00000005, 32'h0);
        branch_case(op_bgtz, 32'h80000000, 32'h0);
        branch_case(op_blez, 32'h00000000, 32'h0);
        branch_case(op_blez, 32'h7fffffff, 32'h0);
    endtask

    task automatic test_calls();
        // link from the call at word 2 points at word 4
        load_call_program(1'b0);
        run_program(1'b0, 200);
        check_value("register_v0", register_v0, reset_vector + 32'd16);
        load_call_program(1'b1);
        run_program(1'b0, 200);
        check_value("register_v0", register_v0, reset_vector + 32'd16);
        load_jump_program();
        run_program(1'b0, 200);
        check_value("register_v0", register_v0, 32'h00000028);
    endtask

    task automatic test_memory();
        word_t value;
        word_t addr;
        value = $urandom;
        addr = 32'h00000200 - 32'd8;
        load_mem_program(value, 32'h00000200, 16'hfff8);
        run_program(1'b0, 200);
        check_value("data_write", word_t'(bus_writes), 32'd1);
        check_value("data_read", word_t'(bus_reads), 32'd1);
        check_value("data_address", write_addr, addr);
        check_value("data_address", read_addr, addr);
        check_value("dmem", dmem[addr[9:2]], value);
        check_value("register_v0", register_v0, value);
    endtask

    task automatic test_stall_halt();
        load_r_program(saved_fn, saved_a, saved_b, saved_sa);
        run_program(1'b1, 2000);
        check_value("register_v0", register_v0, saved_want);
    endtask

    initial begin
        void'($urandom(32'h7c6b0a60));
        reset = 1'b1;
        clk_enable = 1'b0;
        test_r_type();
        test_immediates();
        test_branches();
        test_calls();
        test_memory();
        test_stall_halt();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* mips_core.f */
+incdir+dv
source/mips_pkg.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_regfile.sv
source/mips_execute.sv
source/mips_memwb.sv
source/mips_cpu_harvard.sv
dv/mips_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module mips_tb -f mips_core.f -o mips_tb_sim
./obj_dir/mips_tb_sim
